//--- bench/ooo_retire_props.sv
`timescale 1ns/1ps

module ooo_retire_props (
    input logic                        clock,
    input logic                        reset,
    input logic                        rob_full,
    input rob_pkg::rob_count_t         count,
    input rob_pkg::rob_tag_t           head,
    input rob_pkg::rob_tag_t           tail,
    input logic [rob_pkg::ROB_LEN-1:0] entry_done,
    input logic                        squash
);

    // occupancy agrees with the pointer distance, never above ROB_LEN
    count_matches_pointers: assert property (@(posedge clock) disable iff (reset)
        (count <= rob_pkg::rob_count_t'(rob_pkg::ROB_LEN)) &&
        (rob_pkg::rob_tag_t'(tail - head) == rob_pkg::rob_tag_t'(count)))
        else $error("count %0d does not match head %0d tail %0d", count, head, tail);

    // every slot empty once a squash has taken effect
    squash_empties_slots: assert property (@(posedge clock) disable iff (reset)
        squash |=> (entry_done == '0))
        else $error("slot still holds a result after a squash");

    no_alloc_when_full: assert property (@(posedge clock) disable iff (reset)
        (rob_full && !squash) |=> $stable(tail))
        else $error("tail moved while the ROB is full");

endmodule

bind rob ooo_retire_props u_props (
    .clock      (clock),
    .reset      (reset),
    .rob_full   (rob_full),
    .count      (count),
    .head       (head),
    .tail       (tail),
    .entry_done (entry_done),
    .squash     (squash)
);

//--- bench/retire_patterns.mem
// id dv dest src1 src2 cv ctag cval cmis ridx | full dtag rv rdest rval sq rdval s1b s1t s2b s2t
// hex, one cycle per line; id 1 in-order 2 full 3 zero reg 4 rename 5 squash 6 wrap
1 1 01 00 00 0 0 00000000 0 00 0 0 0 00 00000000 0 00000000 0 0 0 0
1 1 02 01 00 0 0 00000000 0 00 0 1 0 00 00000000 0 00000000 1 0 0 0
1 1 03 02 01 0 0 00000000 0 00 0 2 0 00 00000000 0 00000000 1 1 1 0
1 1 04 00 00 0 0 00000000 0 00 0 3 0 00 00000000 0 00000000 0 0 0 0
1 0 00 00 00 1 3 44444444 0 00 0 4 0 00 00000000 0 00000000 0 0 0 0
1 0 00 00 00 1 2 33333333 0 00 0 4 0 00 00000000 0 00000000 0 0 0 0
1 0 00 00 00 1 1 22222222 0 00 0 4 0 00 00000000 0 00000000 0 0 0 0
1 0 00 00 00 1 0 11111111 0 00 0 4 0 00 00000000 0 00000000 0 0 0 0
1 0 00 00 00 0 0 00000000 0 01 0 4 1 01 11111111 0 00000000 0 0 0 0
1 0 00 00 00 0 0 00000000 0 01 0 4 1 02 22222222 0 11111111 0 0 0 0
1 0 00 00 00 0 0 00000000 0 02 0 4 1 03 33333333 0 22222222 0 0 0 0
1 0 00 00 00 0 0 00000000 0 03 0 4 1 04 44444444 0 33333333 0 0 0 0
1 0 00 01 00 0 0 00000000 0 04 0 4 0 00 00000000 0 44444444 0 0 0 0
2 1 08 00 00 0 0 00000000 0 00 0 4 0 00 00000000 0 00000000 0 0 0 0
2 1 09 00 00 0 0 00000000 0 00 0 5 0 00 00000000 0 00000000 0 0 0 0
2 1 0A 00 00 0 0 00000000 0 00 0 6 0 00 00000000 0 00000000 0 0 0 0
2 1 0B 00 00 0 0 00000000 0 00 0 7 0 00 00000000 0 00000000 0 0 0 0
2 1 0C 00 00 0 0 00000000 0 00 0 0 0 00 00000000 0 00000000 0 0 0 0
2 1 0D 00 00 0 0 00000000 0 00 0 1 0 00 00000000 0 00000000 0 0 0 0
2 1 0E 00 00 0 0 00000000 0 00 0 2 0 00 00000000 0 00000000 0 0 0 0
2 1 0F 00 00 0 0 00000000 0 00 0 3 0 00 00000000 0 00000000 0 0 0 0
2 1 10 00 00 1 4 80000008 0 00 1 4 0 00 00000000 0 00000000 0 0 0 0
2 1 10 00 00 0 0 00000000 0 00 1 4 1 08 80000008 0 00000000 0 0 0 0
2 1 10 08 10 0 0 00000000 0 00 0 4 0 00 00000000 0 00000000 0 0 0 0
2 0 00 10 00 0 0 00000000 0 00 1 5 0 00 00000000 0 00000000 1 4 0 0
2 0 00 00 00 1 5 80000009 0 00 1 5 0 00 00000000 0 00000000 0 0 0 0
2 0 00 00 00 1 6 8000000A 0 00 1 5 1 09 80000009 0 00000000 0 0 0 0
2 0 00 00 00 1 7 8000000B 0 00 0 5 1 0A 8000000A 0 00000000 0 0 0 0
2 0 00 00 00 1 0 8000000C 0 00 0 5 1 0B 8000000B 0 00000000 0 0 0 0
2 0 00 00 00 1 1 8000000D 0 00 0 5 1 0C 8000000C 0 00000000 0 0 0 0
2 0 00 00 00 1 2 8000000E 0 00 0 5 1 0D 8000000D 0 00000000 0 0 0 0
2 0 00 00 00 1 3 8000000F 0 00 0 5 1 0E 8000000E 0 00000000 0 0 0 0
2 0 00 00 00 1 4 80000010 0 00 0 5 1 0F 8000000F 0 00000000 0 0 0 0
2 0 00 00 00 0 0 00000000 0 0F 0 5 1 10 80000010 0 8000000F 0 0 0 0
2 0 00 00 00 0 0 00000000 0 10 0 5 0 00 00000000 0 80000010 0 0 0 0
3 1 00 00 00 0 0 00000000 0 00 0 5 0 00 00000000 0 00000000 0 0 0 0
3 1 14 00 00 1 5 DEADBEEF 0 00 0 6 0 00 00000000 0 00000000 0 0 0 0
3 0 00 00 00 1 6 0000A020 0 00 0 7 1 00 DEADBEEF 0 00000000 0 0 0 0
3 0 00 00 00 0 0 00000000 0 00 0 7 1 14 0000A020 0 00000000 0 0 0 0
3 0 00 00 00 0 0 00000000 0 14 0 7 0 00 00000000 0 0000A020 0 0 0 0
4 1 05 05 00 0 0 00000000 0 00 0 7 0 00 00000000 0 00000000 0 0 0 0
4 0 00 05 00 1 7 00000555 0 00 0 0 0 00 00000000 0 00000000 1 7 0 0
4 0 00 05 00 0 0 00000000 0 00 0 0 1 05 00000555 0 00000000 1 7 0 0
4 1 05 05 00 0 0 00000000 0 00 0 0 0 00 00000000 0 00000000 0 0 0 0
4 1 05 05 00 1 0 00000AAA 0 00 0 1 0 00 00000000 0 00000000 1 0 0 0
4 0 00 05 00 0 0 00000000 0 00 0 2 1 05 00000AAA 0 00000000 1 1 0 0
4 0 00 05 00 1 1 00000BBB 0 00 0 2 0 00 00000000 0 00000000 1 1 0 0
4 0 00 05 00 0 0 00000000 0 00 0 2 1 05 00000BBB 0 00000000 1 1 0 0
4 0 00 05 00 0 0 00000000 0 05 0 2 0 00 00000000 0 00000BBB 0 0 0 0
5 1 00 00 00 0 0 00000000 0 00 0 2 0 00 00000000 0 00000000 0 0 0 0
5 1 15 00 00 0 0 00000000 0 00 0 3 0 00 00000000 0 00000000 0 0 0 0
5 1 16 15 00 0 0 00000000 0 00 0 4 0 00 00000000 0 00000000 1 3 0 0
5 1 17 00 16 1 3 00000021 0 00 0 5 0 00 00000000 0 00000000 0 0 1 4
5 0 00 17 00 1 4 00000022 0 00 0 6 0 00 00000000 0 00000000 1 5 0 0
5 0 00 00 00 1 5 00000023 0 00 0 6 0 00 00000000 0 00000000 0 0 0 0
5 0 00 00 00 1 2 0000B000 1 00 0 6 0 00 00000000 0 00000000 0 0 0 0
5 0 00 15 16 0 0 00000000 0 00 0 6 1 00 0000B000 1 00000000 1 3 1 4
5 0 00 15 16 0 0 00000000 0 15 0 0 0 00 00000000 0 00000000 0 0 0 0
5 0 00 17 05 0 0 00000000 0 05 0 0 0 00 00000000 0 00000BBB 0 0 0 0
6 1 18 00 00 0 0 00000000 0 00 0 0 0 00 00000000 0 00000000 0 0 0 0
6 1 19 00 00 1 0 60000000 0 00 0 1 0 00 00000000 0 00000000 0 0 0 0
6 1 1A 00 00 1 1 60000001 0 00 0 2 1 18 60000000 0 00000000 0 0 0 0
6 1 1B 00 00 1 2 60000002 0 00 0 3 1 19 60000001 0 00000000 0 0 0 0
6 1 1C 00 00 1 3 60000003 0 00 0 4 1 1A 60000002 0 00000000 0 0 0 0
6 1 1D 00 00 1 4 60000004 0 00 0 5 1 1B 60000003 0 00000000 0 0 0 0
6 1 1E 00 00 1 5 60000005 0 00 0 6 1 1C 60000004 0 00000000 0 0 0 0
6 1 1F 00 00 1 6 60000006 0 00 0 7 1 1D 60000005 0 00000000 0 0 0 0
6 1 18 00 00 1 7 60000007 0 00 0 0 1 1E 60000006 0 00000000 0 0 0 0
6 1 19 18 00 1 0 60000008 0 00 0 1 1 1F 60000007 0 00000000 1 0 0 0
6 0 00 18 00 1 1 60000009 0 00 0 2 1 18 60000008 0 00000000 1 0 0 0
6 0 00 18 00 0 0 00000000 0 18 0 2 1 19 60000009 0 60000008 0 0 0 0
6 0 00 00 00 0 0 00000000 0 19 0 2 0 00 00000000 0 60000009 0 0 0 0

//--- bench/tb_ooo_retire.sv
`timescale 1ns/1ps

module tb_ooo_retire;

    localparam int NUM_LINES  = 72;  // lines in the pattern file
    localparam int LINE_WORDS = 21;  // hex words per line
    localparam int CLK_PERIOD = 10;

    logic              clock;
    logic              reset;
    logic              dispatch_valid;
    rob_pkg::reg_idx_t dispatch_dest;
    rob_pkg::reg_idx_t dispatch_src1;
    rob_pkg::reg_idx_t dispatch_src2;
    logic              rob_full;
    rob_pkg::rob_tag_t dispatch_tag;
    logic              src1_busy;
    rob_pkg::rob_tag_t src1_tag;
    logic              src2_busy;
    rob_pkg::rob_tag_t src2_tag;
    logic              cdb_valid;
    rob_pkg::rob_tag_t cdb_tag;
    rob_pkg::data_t    cdb_value;
    logic              cdb_mispredict;
    logic              retire_valid;
    rob_pkg::reg_idx_t retire_dest;
    rob_pkg::data_t    retire_value;
    logic              squash;
    rob_pkg::reg_idx_t read_idx;
    rob_pkg::data_t    read_value;

    logic [31:0] pattern_words [NUM_LINES*LINE_WORDS];

    ooo_retire_top UUT (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_dest  (dispatch_dest),
        .dispatch_src1  (dispatch_src1),
        .dispatch_src2  (dispatch_src2),
        .rob_full       (rob_full),
        .dispatch_tag   (dispatch_tag),
        .src1_busy      (src1_busy),
        .src1_tag       (src1_tag),
        .src2_busy      (src2_busy),
        .src2_tag       (src2_tag),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .cdb_mispredict (cdb_mispredict),
        .retire_valid   (retire_valid),
        .retire_dest    (retire_dest),
        .retire_value   (retire_value),
        .squash         (squash),
        .read_idx       (read_idx),
        .read_value     (read_value)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD/2) clock = ~clock;
    end

    // watchdog, one clock per pattern line plus some slack
    initial begin
        #(NUM_LINES * CLK_PERIOD + 200);
        $display("simulation hung before the last pattern line was checked");
        $display("Checks failed");
        $fatal(1, "watchdog timeout");
    end

    function automatic string test_name(input logic [31:0] id);
        case (id)
            32'd1:   return "in_order_retire";
            32'd2:   return "structural_hazard";
            32'd3:   return "zero_register";
            32'd4:   return "rename_lookup";
            32'd5:   return "mispredict_squash";
            32'd6:   return "wrap_around";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string test, input int line, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s line %0d %s expected %h actual %h",
                     test, line, field, expected, actual);
            $display("Checks failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic apply_line(input int n);
        int base;
        base = n * LINE_WORDS;
        dispatch_valid = pattern_words[base + 1][0];
        dispatch_dest  = pattern_words[base + 2][4:0];
        dispatch_src1  = pattern_words[base + 3][4:0];
        dispatch_src2  = pattern_words[base + 4][4:0];
        cdb_valid      = pattern_words[base + 5][0];
        cdb_tag        = pattern_words[base + 6][2:0];
        cdb_value      = pattern_words[base + 7];
        cdb_mispredict = pattern_words[base + 8][0];
        read_idx       = pattern_words[base + 9][4:0];
    endtask

    task automatic check_line(input int n);
        int    base;
        string name;
        base = n * LINE_WORDS;
        name = test_name(pattern_words[base]);
        check_value(name, n, "rob_full", pattern_words[base + 10], 32'(rob_full));
        check_value(name, n, "dispatch_tag", pattern_words[base + 11], 32'(dispatch_tag));
        check_value(name, n, "retire_valid", pattern_words[base + 12], 32'(retire_valid));
        check_value(name, n, "retire_dest", pattern_words[base + 13], 32'(retire_dest));
        check_value(name, n, "retire_value", pattern_words[base + 14], retire_value);
        check_value(name, n, "squash", pattern_words[base + 15], 32'(squash));
        check_value(name, n, "read_value", pattern_words[base + 16], read_value);
        check_value(name, n, "src1_busy", pattern_words[base + 17], 32'(src1_busy));
        check_value(name, n, "src2_busy", pattern_words[base + 19], 32'(src2_busy));
        // tag only means something while the register is busy
        if (pattern_words[base + 17] != 32'd0) begin
            check_value(name, n, "src1_tag", pattern_words[base + 18], 32'(src1_tag));
        end
        if (pattern_words[base + 19] != 32'd0) begin
            check_value(name, n, "src2_tag", pattern_words[base + 20], 32'(src2_tag));
        end
    endtask

    initial begin
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_dest  = '0;
        dispatch_src1  = '0;
        dispatch_src2  = '0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_value      = '0;
        cdb_mispredict = 1'b0;
        read_idx       = '0;

        $readmemh("bench/retire_patterns.mem", pattern_words);
        // every line starts with a nonzero test id
        if (pattern_words[0] == 32'd0 ||
            pattern_words[(NUM_LINES - 1) * LINE_WORDS] == 32'd0) begin
            $display("pattern file is missing or shorter than expected");
            $display("Checks failed");
            $fatal(1, "bad pattern file");
        end

        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int n = 0; n < NUM_LINES; n++) begin
            apply_line(n);  // 1 ns after the edge
            #8;
            check_line(n);  // just before the next edge
            @(posedge clock);
            #1;
        end

        $display("All checks passed");
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the retirement block testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ooo_retire \
    -f tb.f \
    -o sim_ooo_retire

# the simulator exits nonzero on any $fatal
./obj_dir/sim_ooo_retire

//--- tb.f
verilog/rob_pkg.sv
verilog/rob_commit_if.sv
verilog/rob_entry.sv
verilog/rob.sv
verilog/map_table.sv
verilog/arch_regfile.sv
verilog/ooo_retire_top.sv
bench/ooo_retire_props.sv
bench/tb_ooo_retire.sv

//--- verilog/arch_regfile.sv
`timescale 1ns/1ps

module arch_regfile (
    input  logic              clock,
    input  logic              reset,
    rob_commit_if.consumer    commit,
    input  rob_pkg::reg_idx_t read_idx,
    output rob_pkg::data_t    read_value
);

    rob_pkg::data_t regs [rob_pkg::REG_LEN];

    // write on retire, register 0 stays untouched
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rob_pkg::REG_LEN; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid && (commit.dest != rob_pkg::ZERO_REG)) begin
            regs[commit.dest] <= commit.value;
        end
    end

    // debug read port
    assign read_value = (read_idx == rob_pkg::ZERO_REG) ? '0 : regs[read_idx];

endmodule

//--- verilog/map_table.sv
`timescale 1ns/1ps

module map_table (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  logic              rob_full,
    input  rob_pkg::reg_idx_t dispatch_dest,
    input  rob_pkg::rob_tag_t dispatch_tag,
    input  rob_pkg::reg_idx_t src1,
    input  rob_pkg::reg_idx_t src2,
    output logic              src1_busy,
    output rob_pkg::rob_tag_t src1_tag,
    output logic              src2_busy,
    output rob_pkg::rob_tag_t src2_tag,
    rob_commit_if.consumer    commit
);

    logic [rob_pkg::REG_LEN-1:0] busy;                       // register has an in-flight producer
    rob_pkg::rob_tag_t           map_tag [rob_pkg::REG_LEN];  // tag of that producer

    logic rename;

    // only accepted dispatches that write a real register get renamed
    assign rename = dispatch_valid && !rob_full && (dispatch_dest != rob_pkg::ZERO_REG);

    // source lookups
    assign src1_busy = busy[src1];
    assign src1_tag  = map_tag[src1];
    assign src2_busy = busy[src2];
    assign src2_tag  = map_tag[src2];

    always_ff @(posedge clock) begin
        if (reset || commit.squash) begin
            busy <= '0;
        end else begin
            // release only if no younger producer took the register over
            if (commit.valid && (map_tag[commit.dest] == commit.tag)) begin
                busy[commit.dest] <= 1'b0;
            end
            // later assignment, so a same-cycle remap wins over the release
            if (rename) begin
                busy[dispatch_dest] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rename) begin
            map_tag[dispatch_dest] <= dispatch_tag;
        end
    end

endmodule

//--- verilog/ooo_retire_top.sv
`timescale 1ns/1ps

module ooo_retire_top (
    input  logic              clock,
    input  logic              reset,
    // decode side
    input  logic              dispatch_valid,
    input  rob_pkg::reg_idx_t dispatch_dest,
    input  rob_pkg::reg_idx_t dispatch_src1,
    input  rob_pkg::reg_idx_t dispatch_src2,
    output logic              rob_full,
    output rob_pkg::rob_tag_t dispatch_tag,
    output logic              src1_busy,
    output rob_pkg::rob_tag_t src1_tag,
    output logic              src2_busy,
    output rob_pkg::rob_tag_t src2_tag,
    // common data bus
    input  logic              cdb_valid,
    input  rob_pkg::rob_tag_t cdb_tag,
    input  rob_pkg::data_t    cdb_value,
    input  logic              cdb_mispredict,
    // retire side
    output logic              retire_valid,
    output rob_pkg::reg_idx_t retire_dest,
    output rob_pkg::data_t    retire_value,
    output logic              squash,
    // register file read
    input  rob_pkg::reg_idx_t read_idx,
    output rob_pkg::data_t    read_value
);

    rob_commit_if commit_bus ();

    rob u_rob (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_dest  (dispatch_dest),
        .dispatch_tag   (dispatch_tag),
        .rob_full       (rob_full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .cdb_mispredict (cdb_mispredict),
        .commit         (commit_bus)
    );

    map_table u_map_table (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .rob_full       (rob_full),
        .dispatch_dest  (dispatch_dest),
        .dispatch_tag   (dispatch_tag),
        .src1           (dispatch_src1),
        .src2           (dispatch_src2),
        .src1_busy      (src1_busy),
        .src1_tag       (src1_tag),
        .src2_busy      (src2_busy),
        .src2_tag       (src2_tag),
        .commit         (commit_bus)
    );

    arch_regfile u_regfile (
        .clock      (clock),
        .reset      (reset),
        .commit     (commit_bus),
        .read_idx   (read_idx),
        .read_value (read_value)
    );

    // retire event straight out to the pins
    assign retire_valid = commit_bus.valid;
    assign retire_dest  = commit_bus.dest;
    assign retire_value = commit_bus.value;
    assign squash       = commit_bus.squash;

endmodule

//--- verilog/rob.sv
`timescale 1ns/1ps

module rob (
    input  logic                   clock,
    input  logic                   reset,
    // decode side
    input  logic                   dispatch_valid,
    input  rob_pkg::reg_idx_t      dispatch_dest,
    output rob_pkg::rob_tag_t      dispatch_tag,
    output logic                   rob_full,
    // common data bus
    input  logic                   cdb_valid,
    input  rob_pkg::rob_tag_t      cdb_tag,
    input  rob_pkg::data_t         cdb_value,
    input  logic                   cdb_mispredict,
    // retire / squash event
    rob_commit_if.producer         commit
);

    rob_pkg::rob_tag_t   head;
    rob_pkg::rob_tag_t   tail;
    rob_pkg::rob_count_t count;

    logic dispatch_fire;
    logic retire;
    logic squash;

    // per-slot strobes and state
    logic [rob_pkg::ROB_LEN-1:0] alloc;
    logic [rob_pkg::ROB_LEN-1:0] complete;
    logic [rob_pkg::ROB_LEN-1:0] clear;
    logic [rob_pkg::ROB_LEN-1:0] entry_done;
    logic [rob_pkg::ROB_LEN-1:0] entry_mispredict;
    rob_pkg::reg_idx_t           entry_dest  [rob_pkg::ROB_LEN];
    rob_pkg::data_t              entry_value [rob_pkg::ROB_LEN];

    assign rob_full      = (count == rob_pkg::rob_count_t'(rob_pkg::ROB_LEN));
    assign dispatch_tag  = tail;  // new instruction's tag is its slot
    assign dispatch_fire = dispatch_valid && !rob_full;

    // head retires as soon as its result is in
    assign retire = entry_done[head];
    assign squash = retire && entry_mispredict[head];

    for (genvar i = 0; i < rob_pkg::ROB_LEN; i++) begin : g_slot
        assign alloc[i]    = dispatch_fire && (tail == rob_pkg::rob_tag_t'(i));
        assign complete[i] = cdb_valid && (cdb_tag == rob_pkg::rob_tag_t'(i));
        assign clear[i]    = squash || (retire && (head == rob_pkg::rob_tag_t'(i)));

        rob_entry u_entry (
            .clock               (clock),
            .reset               (reset),
            .alloc               (alloc[i]),
            .alloc_dest          (dispatch_dest),
            .complete            (complete[i]),
            .complete_value      (cdb_value),
            .complete_mispredict (cdb_mispredict),
            .clear               (clear[i]),
            .done                (entry_done[i]),
            .dest                (entry_dest[i]),
            .value               (entry_value[i]),
            .mispredict          (entry_mispredict[i])
        );
    end

    // pointers and occupancy
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head  <= '0;  // a squash drops everything younger than the branch
            tail  <= '0;
            count <= '0;
        end else begin
            if (retire) begin
                head <= head + rob_pkg::rob_tag_t'(1);  // wraps at ROB_LEN
            end
            if (dispatch_fire) begin
                tail <= tail + rob_pkg::rob_tag_t'(1);
            end
            case ({dispatch_fire, retire})
                2'b10:   count <= count + rob_pkg::rob_count_t'(1);
                2'b01:   count <= count - rob_pkg::rob_count_t'(1);
                default: count <= count;  // none, or one in and one out
            endcase
        end
    end

    // retire event, dest and value held at zero when idle
    assign commit.valid  = retire;
    assign commit.squash = squash;
    assign commit.tag    = head;
    assign commit.dest   = retire ? entry_dest[head] : rob_pkg::ZERO_REG;
    assign commit.value  = retire ? entry_value[head] : '0;

endmodule

//--- verilog/rob_commit_if.sv
`timescale 1ns/1ps

// retire and squash event, one per cycle at most
interface rob_commit_if;

    logic               valid;   // head entry retires this cycle
    rob_pkg::reg_idx_t  dest;    // destination of the retiring entry
    rob_pkg::data_t     value;   // its result
    rob_pkg::rob_tag_t  tag;     // its slot
    logic               squash;  // retiring entry was mispredicted

    modport producer (
        output valid, dest, value, tag, squash
    );

    modport consumer (
        input valid, dest, value, tag, squash
    );

endinterface

//--- verilog/rob_entry.sv
`timescale 1ns/1ps

module rob_entry (
    input  logic              clock,
    input  logic              reset,
    input  logic              alloc,                // slot taken by dispatch
    input  rob_pkg::reg_idx_t alloc_dest,
    input  logic              complete,             // cdb write to this slot
    input  rob_pkg::data_t    complete_value,
    input  logic              complete_mispredict,
    input  logic              clear,                // squash or own retire
    output logic              done,
    output rob_pkg::reg_idx_t dest,
    output rob_pkg::data_t    value,
    output logic              mispredict
);

    // status bits
    always_ff @(posedge clock) begin
        if (reset || clear) begin
            done       <= 1'b0;
            mispredict <= 1'b0;
        end else if (alloc) begin
            done       <= 1'b0;  // fresh instruction, result pending
            mispredict <= 1'b0;
        end else if (complete) begin
            done       <= 1'b1;
            mispredict <= complete_mispredict;
        end
    end

    // payload, only meaningful while done is set
    always_ff @(posedge clock) begin
        if (alloc) begin
            dest <= alloc_dest;
        end
        if (complete) begin
            value <= complete_value;
        end
    end

endmodule

//--- verilog/rob_pkg.sv
package rob_pkg;

    // sizes of the retirement block
    localparam int ROB_LEN = 8;   // reorder buffer slots
    localparam int REG_LEN = 32;  // architectural registers
    localparam int XLEN    = 32;  // result width

    // slot index doubles as the instruction tag
    typedef logic [$clog2(ROB_LEN)-1:0] rob_tag_t;

    // occupancy needs one more bit than the tag to reach ROB_LEN
    typedef logic [$clog2(ROB_LEN):0]   rob_count_t;

    typedef logic [$clog2(REG_LEN)-1:0] reg_idx_t;
    typedef logic [XLEN-1:0]            data_t;

    // hard-wired zero register, never written or renamed
    localparam reg_idx_t ZERO_REG = '0;

endpackage
